/* hdl/board_pkg.sv */
package board_pkg;

	typedef logic [3:0] nibble_t;   // One hex/decimal digit, also ALU width
	typedef logic [7:0] seg_t;      // dp g f e d c b a, active low
	typedef logic [7:0] count_t;
	typedef logic [2:0] alu_op_t;

	localparam int NUM_DIGITS = 8;
	localparam count_t COUNT_MAX = 8'd99;

	// All segments dark, dp included
	localparam seg_t SEG_OFF = 8'hFF;

	// Where each value lands on the display
	localparam int DIG_UNITS = 0;
	localparam int DIG_TENS = 1;
	localparam int DIG_ALU = 4;
	localparam int DIG_SW_LO = 6;
	localparam int DIG_SW_HI = 7;

	localparam alu_op_t ALU_ADD = 3'd0;
	localparam alu_op_t ALU_SUB = 3'd1;
	localparam alu_op_t ALU_NOT = 3'd2;
	localparam alu_op_t ALU_AND = 3'd3;
	localparam alu_op_t ALU_OR = 3'd4;
	localparam alu_op_t ALU_XOR = 3'd5;
	localparam alu_op_t ALU_SLT = 3'd6;   // Signed compare
	localparam alu_op_t ALU_EQ = 3'd7;

endpackage

/* hdl/disp_if.sv */
`timescale 1ns/1ps

interface disp_if import board_pkg::*; ();

	nibble_t digit [NUM_DIGITS];
	logic blank [NUM_DIGITS];
	logic dp [NUM_DIGITS];
	seg_t pattern [NUM_DIGITS];   // One entry per decoder

	modport split (
		output digit,
		output blank,
		output dp
	);

	modport dec (
		input digit,
		input blank,
		input dp,
		output pattern
	);

	modport scan (
		input pattern
	);

endinterface

/* hdl/tick_timer.sv */
`timescale 1ns/1ps

module tick_timer #(
	parameter int TICK_DIV = 50_000_000
) (
	input logic clk,
	input logic arst_n,
	output logic tick
);

	localparam int CW = ($clog2(TICK_DIV) > 0) ? $clog2(TICK_DIV) : 1;
	localparam logic [CW-1:0] RELOAD = CW'(TICK_DIV - 1);

	logic [CW-1:0] cnt;

	// Down counter, one pulse per wrap
	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			cnt <= RELOAD;
			tick <= 1'b0;
		end else if (cnt == '0) begin
			cnt <= RELOAD;
			tick <= 1'b1;
		end else begin
			cnt <= cnt - 1'b1;
			tick <= 1'b0;
		end
	end

endmodule

/* hdl/dec_counter.sv */
`timescale 1ns/1ps

module dec_counter import board_pkg::*; (
	input logic clk,
	input logic arst_n,
	input logic tick,
	input logic count_en,
	output count_t count
);

	logic step;

	assign step = tick & count_en;

	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			count <= '0;
		end else if (step) begin
			if (count >= COUNT_MAX)
				count <= '0;   // Wrap after 99
			else
				count <= count + 1'b1;
		end
	end

endmodule

/* hdl/alu_4bit.sv */
`timescale 1ns/1ps

module alu_4bit import board_pkg::*; (
	input alu_op_t op,
	input nibble_t a,
	input nibble_t b,
	output nibble_t res,
	output logic zero,
	output logic carry,
	output logic overflow
);

	logic [4:0] sum;
	logic [4:0] diff;
	logic add_ovf;
	logic sub_ovf;

	assign sum = {1'b0, a} + {1'b0, b};
	assign diff = {1'b0, a} + {1'b0, ~b} + 5'd1;   // a + ~b + 1

	// Signed overflow from the operand and result signs
	assign add_ovf = (a[3] == b[3]) && (sum[3] != a[3]);
	assign sub_ovf = (a[3] != b[3]) && (diff[3] != a[3]);

	always_comb begin
		res = '0;
		carry = 1'b0;
		overflow = 1'b0;
		case (op)
			ALU_ADD: begin
				res = sum[3:0];
				carry = sum[4];
				overflow = add_ovf;
			end
			ALU_SUB: begin
				res = diff[3:0];
				carry = diff[4];
				overflow = sub_ovf;
			end
			ALU_NOT: res = ~a;
			ALU_AND: res = a & b;
			ALU_OR: res = a | b;
			ALU_XOR: res = a ^ b;
			ALU_SLT: res = {3'b000, $signed(a) < $signed(b)};
			ALU_EQ: res = {3'b000, a == b};
			default: res = '0;
		endcase
	end

	assign zero = (res == '0);

endmodule

/* hdl/digit_split.sv */
`timescale 1ns/1ps

module digit_split import board_pkg::*; (
	input count_t count,
	input nibble_t alu_res,
	input logic alu_carry,
	input logic [7:0] sw,
	disp_if.split disp
);

	count_t units;
	count_t tens;

	assign units = count % 8'd10;
	assign tens = count / 8'd10;   // At most 9 while count stays in range

	always_comb begin
		// Unused positions stay dark
		for (int i = 0; i < NUM_DIGITS; i++) begin
			disp.digit[i] = '0;
			disp.blank[i] = 1'b1;
			disp.dp[i] = 1'b0;
		end

		disp.digit[DIG_UNITS] = units[3:0];
		disp.blank[DIG_UNITS] = 1'b0;

		disp.digit[DIG_TENS] = tens[3:0];
		disp.blank[DIG_TENS] = (tens == '0);   // No leading zero

		disp.digit[DIG_ALU] = alu_res;
		disp.blank[DIG_ALU] = 1'b0;
		disp.dp[DIG_ALU] = alu_carry;   // Carry shown on the dp

		disp.digit[DIG_SW_LO] = sw[3:0];
		disp.blank[DIG_SW_LO] = 1'b0;

		disp.digit[DIG_SW_HI] = sw[7:4];
		disp.blank[DIG_SW_HI] = 1'b0;
	end

endmodule

/* hdl/seg_decode.sv */
`timescale 1ns/1ps

module seg_decode import board_pkg::*; #(
	parameter int IDX = 0
) (
	disp_if.dec disp
);

	logic [6:0] glyph;   // g..a, active low
	seg_t pat;

	always_comb begin
		case (disp.digit[IDX])
			4'h0: glyph = 7'h40;
			4'h1: glyph = 7'h79;
			4'h2: glyph = 7'h24;
			4'h3: glyph = 7'h30;
			4'h4: glyph = 7'h19;
			4'h5: glyph = 7'h12;
			4'h6: glyph = 7'h02;
			4'h7: glyph = 7'h78;
			4'h8: glyph = 7'h00;
			4'h9: glyph = 7'h10;
			4'hA: glyph = 7'h08;
			4'hB: glyph = 7'h03;   // Lower case b
			4'hC: glyph = 7'h46;
			4'hD: glyph = 7'h21;   // Lower case d
			4'hE: glyph = 7'h06;
			default: glyph = 7'h0E;
		endcase
	end

	always_comb begin
		pat = SEG_OFF;
		if (!disp.blank[IDX])
			pat[6:0] = glyph;
		// dp still lights on a blanked digit
		pat[7] = ~disp.dp[IDX];
	end

	assign disp.pattern[IDX] = pat;

endmodule

/* hdl/seg_scan.sv */
`timescale 1ns/1ps

module seg_scan import board_pkg::*; #(
	parameter int SCAN_DIV = 50_000
) (
	input logic clk,
	input logic arst_n,
	disp_if.scan disp,
	output seg_t seg,
	output logic [NUM_DIGITS-1:0] seg_sel
);

	localparam int DW = ($clog2(SCAN_DIV) > 0) ? $clog2(SCAN_DIV) : 1;
	localparam int IW = $clog2(NUM_DIGITS);
	localparam logic [DW-1:0] DWELL_LAST = DW'(SCAN_DIV - 1);

	logic [DW-1:0] dwell;
	logic [IW-1:0] idx;

	// Dwell timer and digit index
	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			dwell <= '0;
			idx <= '0;
		end else if (dwell == DWELL_LAST) begin
			dwell <= '0;
			idx <= idx + 1'b1;   // Wraps at NUM_DIGITS
		end else begin
			dwell <= dwell + 1'b1;
		end
	end

	// Output stage, one cycle behind idx
	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			seg <= SEG_OFF;
			seg_sel <= '1;
		end else begin
			seg <= disp.pattern[idx];
			seg_sel <= ~(NUM_DIGITS'(1) << idx);
		end
	end

endmodule

/* hdl/board_top.sv */
`timescale 1ns/1ps

module board_top import board_pkg::*; #(
	parameter int TICK_DIV = 50_000_000,
	parameter int SCAN_DIV = 50_000
) (
	input logic clk,
	input logic arst_n,
	input logic [7:0] sw,
	input logic count_en,
	input logic [2:0] alu_op,
	input logic [3:0] alu_a,
	input logic [3:0] alu_b,
	output logic [7:0] ledr,
	output logic [7:0] count,
	output logic [3:0] alu_res,
	output logic alu_zero,
	output logic alu_carry,
	output logic alu_overflow,
	output logic [7:0] seg,
	output logic [7:0] seg_sel
);

	logic tick;

	disp_if u_disp ();

	assign ledr = sw;

	tick_timer #(
		.TICK_DIV(TICK_DIV)
	) u_timer (
		.clk(clk),
		.arst_n(arst_n),
		.tick(tick)
	);

	dec_counter u_counter (
		.clk(clk),
		.arst_n(arst_n),
		.tick(tick),
		.count_en(count_en),
		.count(count)
	);

	alu_4bit u_alu (
		.op(alu_op),
		.a(alu_a),
		.b(alu_b),
		.res(alu_res),
		.zero(alu_zero),
		.carry(alu_carry),
		.overflow(alu_overflow)
	);

	digit_split u_split (
		.count(count),
		.alu_res(alu_res),
		.alu_carry(alu_carry),
		.sw(sw),
		.disp(u_disp)
	);

	// One decoder per display digit
	for (genvar i = 0; i < NUM_DIGITS; i++) begin : g_dig
		seg_decode #(
			.IDX(i)
		) u_dec (
			.disp(u_disp)
		);
	end

	seg_scan #(
		.SCAN_DIV(SCAN_DIV)
	) u_scan (
		.clk(clk),
		.arst_n(arst_n),
		.disp(u_disp),
		.seg(seg),
		.seg_sel(seg_sel)
	);

endmodule

/* test/tb_clk_gen.sv */
`timescale 1ns/1ps

module tb_clk_gen #(
	parameter int PERIOD_NS = 4,
	parameter int RESET_CYCLES = 16
) (
	output logic clk,
	output logic arst_n
);

	initial begin
		clk = 1'b0;
		forever #(PERIOD_NS / 2.0) clk = ~clk;
	end

	initial begin
		arst_n = 1'b0;
		repeat (RESET_CYCLES) @(posedge clk);
		#0.5 arst_n = 1'b1;   // Released just after an edge
	end

endmodule

/* test/tb_board.sv */
`timescale 1ns/1ps

module tb_board;

	localparam int TICK_DIV = 20;
	localparam int SCAN_DIV = 3;
	localparam int CLK_PERIOD = 4;
	localparam int NUM_VECTORS = 400;
	localparam int WRAP_TICKS = 130;
	localparam int HOLD_CYCLES = 40;
	localparam real WATCHDOG_NS =
		real'((NUM_VECTORS + WRAP_TICKS * TICK_DIV + 200) * CLK_PERIOD);

	logic clk;
	logic arst_n;
	logic [7:0] sw;
	logic count_en;
	logic [2:0] alu_op;
	logic [3:0] alu_a;
	logic [3:0] alu_b;
	logic [7:0] ledr;
	logic [7:0] count;
	logic [3:0] alu_res;
	logic alu_zero;
	logic alu_carry;
	logic alu_overflow;
	logic [7:0] seg;
	logic [7:0] seg_sel;

	int value_errors = 0;
	int other_errors = 0;
	logic [31:0] rng = 32'd24336;
	bit wrapped = 1'b0;

	// Cycle model of the board
	int m_timer;
	bit m_tick;
	int m_count;
	int m_dwell;
	int m_idx;
	logic [7:0] m_seg;
	logic [7:0] m_sel;
	bit m_selecting;

	// Inputs as they stood at the last edge
	bit p_rst = 1'b0;
	logic [7:0] p_sw;
	logic p_en;
	logic [2:0] p_op;
	logic [3:0] p_a;
	logic [3:0] p_b;

	tb_clk_gen #(
		.PERIOD_NS(CLK_PERIOD),
		.RESET_CYCLES(16)
	) u_clk (
		.clk(clk),
		.arst_n(arst_n)
	);

	board_top #(
		.TICK_DIV(TICK_DIV),
		.SCAN_DIV(SCAN_DIV)
	) u_dut (
		.clk(clk),
		.arst_n(arst_n),
		.sw(sw),
		.count_en(count_en),
		.alu_op(alu_op),
		.alu_a(alu_a),
		.alu_b(alu_b),
		.ledr(ledr),
		.count(count),
		.alu_res(alu_res),
		.alu_zero(alu_zero),
		.alu_carry(alu_carry),
		.alu_overflow(alu_overflow),
		.seg(seg),
		.seg_sel(seg_sel)
	);

	function automatic logic [31:0] xorshift32(input logic [31:0] x);
		logic [31:0] y;
		y = x ^ (x << 13);
		y = y ^ (y >> 17);
		y = y ^ (y << 5);
		return y;
	endfunction

	// Returns {overflow, carry, zero, res}
	function automatic logic [6:0] ref_alu(input logic [2:0] op, input logic [3:0] a,
			input logic [3:0] b);
		int sa;
		int sb;
		int wide;
		logic [3:0] r;
		logic c;
		logic v;
		sa = $signed(a);
		sb = $signed(b);
		c = 1'b0;
		v = 1'b0;
		case (op)
			3'd0: begin
				wide = a + b;
				r = wide[3:0];
				c = (wide > 15);
				v = (sa + sb > 7) || (sa + sb < -8);
			end
			3'd1: begin
				r = a - b;
				c = (a >= b);   // No borrow
				v = (sa - sb > 7) || (sa - sb < -8);
			end
			3'd2: r = ~a;
			3'd3: r = a & b;
			3'd4: r = a | b;
			3'd5: r = a ^ b;
			3'd6: r = (sa < sb) ? 4'd1 : 4'd0;
			default: r = (a == b) ? 4'd1 : 4'd0;
		endcase
		return {v, c, (r == 4'd0), r};
	endfunction

	// Maps {dp, blank, digit} to the active low dp g f e d c b a pattern
	function automatic logic [7:0] ref_seg(input logic [5:0] d);
		logic [6:0] g;
		case (d[3:0])
			4'h0: g = 7'b1000000;
			4'h1: g = 7'b1111001;
			4'h2: g = 7'b0100100;
			4'h3: g = 7'b0110000;
			4'h4: g = 7'b0011001;
			4'h5: g = 7'b0010010;
			4'h6: g = 7'b0000010;
			4'h7: g = 7'b1111000;
			4'h8: g = 7'b0000000;
			4'h9: g = 7'b0010000;
			4'hA: g = 7'b0001000;
			4'hB: g = 7'b0000011;
			4'hC: g = 7'b1000110;
			4'hD: g = 7'b0100001;
			4'hE: g = 7'b0000110;
			default: g = 7'b0001110;
		endcase
		if (d[4])
			g = 7'b1111111;
		return {~d[5], g};
	endfunction

	function automatic logic [5:0] ref_digit(input int idx, input int cnt,
			input logic [3:0] res, input logic carry, input logic [7:0] sws);
		case (idx)
			0: return {1'b0, 1'b0, 4'(cnt % 10)};
			1: return {1'b0, (cnt / 10) == 0, 4'(cnt / 10)};
			4: return {carry, 1'b0, res};
			6: return {1'b0, 1'b0, sws[3:0]};
			7: return {1'b0, 1'b0, sws[7:4]};
			default: return {1'b0, 1'b1, 4'h0};
		endcase
	endfunction

	task automatic compare_value(input string name, input logic [31:0] expected,
			input logic [31:0] actual);
		assert (actual === expected)
		else begin
			value_errors++;
			$display("Fail at %0.1f ns: %s expected %0h, got %0h", $realtime, name,
				expected, actual);
		end
	endtask

	task automatic reset_model();
		m_timer = TICK_DIV - 1;
		m_tick = 1'b0;
		m_count = 0;
		m_dwell = 0;
		m_idx = 0;
		m_seg = 8'hFF;
		m_sel = 8'hFF;
		m_selecting = 1'b0;
	endtask

	// Advances the model by one rising edge with the inputs held over it
	task automatic step_model();
		logic [6:0] alu_prev;
		logic [5:0] dig;
		alu_prev = ref_alu(p_op, p_a, p_b);
		dig = ref_digit(m_idx, m_count, alu_prev[3:0], alu_prev[5], p_sw);
		m_seg = ref_seg(dig);
		m_sel = ~(8'b1 << m_idx);
		m_selecting = 1'b1;
		if (m_tick && p_en) begin
			if (m_count == 99) begin
				m_count = 0;
				wrapped = 1'b1;
			end else begin
				m_count++;
			end
		end
		m_tick = (m_timer == 0);
		m_timer = m_tick ? TICK_DIV - 1 : m_timer - 1;
		if (m_dwell == SCAN_DIV - 1) begin
			m_dwell = 0;
			m_idx = (m_idx + 1) % 8;
		end else begin
			m_dwell++;
		end
	endtask

	task automatic compare_outputs();
		logic [6:0] alu_exp;
		alu_exp = ref_alu(alu_op, alu_a, alu_b);
		compare_value("ledr", sw, ledr);
		compare_value("alu_res", alu_exp[3:0], alu_res);
		compare_value("alu_zero", alu_exp[4], alu_zero);
		compare_value("alu_carry", alu_exp[5], alu_carry);
		compare_value("alu_overflow", alu_exp[6], alu_overflow);
		compare_value("count", m_count, count);
		compare_value("seg_sel", m_sel, seg_sel);
		compare_value("seg", m_seg, seg);
		if (m_selecting) begin
			assert ($countones(~seg_sel) == 1)
			else begin
				other_errors++;
				$display("At %0.1f ns seg_sel does not select exactly one digit",
					$realtime);
			end
		end
	endtask

	task automatic sample_inputs();
		p_rst = arst_n;
		p_sw = sw;
		p_en = count_en;
		p_op = alu_op;
		p_a = alu_a;
		p_b = alu_b;
	endtask

	task automatic drive_random();
		rng = xorshift32(rng);
		alu_op = rng[2:0];
		alu_a = rng[6:3];
		alu_b = rng[10:7];
		sw = rng[18:11];
	endtask

	// Compares just after each rising edge once the inputs have moved
	initial begin : check_proc
		forever begin
			@(posedge clk);
			#1;
			if (!arst_n)
				reset_model();
			else if (p_rst)
				step_model();
			compare_outputs();
			sample_inputs();
		end
	end

	initial begin : stimulus
		sw = '0;
		count_en = 1'b0;
		alu_op = '0;
		alu_a = '0;
		alu_b = '0;
		wait (arst_n === 1'b1);
		for (int n = 0; n < NUM_VECTORS; n++) begin
			@(posedge clk);
			#0.5;
			count_en = 1'b1;
			drive_random();
		end
		@(posedge clk);
		#0.5 count_en = 1'b0;   // Count must hold over a few ticks
		repeat (HOLD_CYCLES) @(posedge clk);
		#0.5 count_en = 1'b1;
		for (int n = 0; !wrapped; n++) begin
			@(posedge clk);
			#0.5;
			if (n % 8 == 0)
				drive_random();
		end
		repeat (40) @(posedge clk);
		$display("Checks done: %0d value errors, %0d other errors", value_errors,
			other_errors);
		if (value_errors == 0 && other_errors == 0) begin
			$display("TESTBENCH PASSED");
		end else begin
			$display("TESTBENCH FAILED");
		end
		$finish;
	end

	initial begin : watchdog
		#(WATCHDOG_NS);
		other_errors++;
		$display("Timeout: the counter never wrapped within %0.1f ns", WATCHDOG_NS);
		$display("TESTBENCH FAILED");
		$finish;
	end

endmodule

/* src.f */
hdl/board_pkg.sv
hdl/disp_if.sv
hdl/tick_timer.sv
hdl/dec_counter.sv
hdl/alu_4bit.sv
hdl/digit_split.sv
hdl/seg_decode.sv
hdl/seg_scan.sv
hdl/board_top.sv
test/tb_clk_gen.sv
test/tb_board.sv

/* run.sh */
#!/bin/sh
# Build and run the board testbench with Verilator
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal -f src.f --top-module tb_board -o tb_board
if [ $? -ne 0 ]; then
	echo "Verilator build failed"
	exit 1
fi

out=$(./obj_dir/tb_board)
status=$?
printf '%s\n' "$out"
if [ $status -ne 0 ]; then
	echo "Simulation exited with status $status"
	exit 1
fi

if printf '%s\n' "$out" | grep -q "^TESTBENCH PASSED$"; then
	exit 0
fi
echo "Pass message not found in the simulation output"
exit 1
